//--- Bender.yml
package:
  name: osnt_input_arbiter

sources:
  - files:
      - hdl/arb_pkg.sv
      - hdl/fallthrough_small_fifo.sv
      - hdl/input_arbiter_fsm.sv
      - hdl/pkt_counter.sv
      - hdl/osnt_input_arbiter.sv
  - target: test
    files:
      - tests/input_arbiter_assertions.sv
      - tests/tb_input_arbiter.sv

//--- hdl/arb_pkg.sv
package arb_pkg;

   // Stream widths
   localparam int unsigned DATA_W = 64;
   localparam int unsigned STRB_W = DATA_W / 8;  // One strobe bit per byte
   localparam int unsigned USER_W = 16;

   // Input side
   localparam int unsigned NUM_QUEUES = 4;
   localparam int unsigned QUEUE_W    = 2;        // Enough to index NUM_QUEUES

   // Input FIFO geometry
   localparam int unsigned FIFO_DEPTH_BITS = 4;
   localparam int unsigned FIFO_DEPTH      = 1 << FIFO_DEPTH_BITS;  // 16 words

   // FIFO word is {tlast, tuser, tstrb, tdata}
   localparam int unsigned FIFO_W = 1 + USER_W + STRB_W + DATA_W;

   // tready drops one word before the FIFO is full
   localparam int unsigned NEARLY_FULL_LEVEL = 15;

   // Per-queue packet statistics
   localparam int unsigned PKT_CNT_W = 16;

   typedef enum logic {
      ARB_IDLE,    // Searching for a non-empty queue
      ARB_WR_PKT   // Locked on current queue until tlast
   } arb_state_t;

endpackage

//--- hdl/fallthrough_small_fifo.sv
`timescale 1ns/1ps

module fallthrough_small_fifo
   import arb_pkg::*;
(
   input  logic              axi_aclk,
   input  logic              axi_resetn,
   input  logic [FIFO_W-1:0] din,
   input  logic              wr_en,
   input  logic              rd_en,
   output logic [FIFO_W-1:0] dout,
   output logic              empty,
   output logic              nearly_full
);

   logic [FIFO_W-1:0]          mem [FIFO_DEPTH];  // Word storage
   logic [FIFO_DEPTH_BITS-1:0] wr_ptr;            // Next slot to write
   logic [FIFO_DEPTH_BITS-1:0] rd_ptr;            // Head of queue
   logic [FIFO_DEPTH_BITS:0]   depth;             // Occupancy, 0 to FIFO_DEPTH
   logic                       full;
   logic                       do_wr;
   logic                       do_rd;

   // MSB only set when every slot is taken
   assign full = depth[FIFO_DEPTH_BITS];

   assign empty       = (depth == '0);
   assign nearly_full = (depth >= NEARLY_FULL_LEVEL);

   // Drop illegal requests
   assign do_wr = wr_en & ~full;
   assign do_rd = rd_en & ~empty;

   // Head word always on the output, no read latency
   assign dout = mem[rd_ptr];

   // Storage array
   always_ff @(posedge axi_aclk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   // Pointers wrap naturally at FIFO_DEPTH
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;  // Pop the head
         end
      end
   end

   // Occupancy tracking
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         depth <= '0;
      end else begin
         case ({do_wr, do_rd})
            2'b10:   depth <= depth + 1'b1;  // Push only
            2'b01:   depth <= depth - 1'b1;  // Pop only
            default: depth <= depth;         // Both or neither
         endcase
      end
   end

endmodule

//--- hdl/input_arbiter_fsm.sv
`timescale 1ns/1ps

module input_arbiter_fsm
   import arb_pkg::*;
(
   input  logic                  axi_aclk,
   input  logic                  axi_resetn,
   input  logic [NUM_QUEUES-1:0] empty,
   input  logic [FIFO_W-1:0]     head_word [NUM_QUEUES],
   input  logic                  m_axis_tready,
   output logic [DATA_W-1:0]     m_axis_tdata,
   output logic [STRB_W-1:0]     m_axis_tstrb,
   output logic [USER_W-1:0]     m_axis_tuser,
   output logic                  m_axis_tlast,
   output logic                  m_axis_tvalid,
   output logic [NUM_QUEUES-1:0] rd_en,
   output logic [QUEUE_W-1:0]    cur_queue,
   output logic                  pkt_done
);

   arb_state_t         state;
   arb_state_t         state_next;
   logic [QUEUE_W-1:0] cur_queue_next;
   logic [QUEUE_W-1:0] cur_queue_plus1;  // Round-robin successor
   logic [FIFO_W-1:0]  cur_word;         // Head of selected FIFO
   logic               xfer;             // Output beat this cycle

   // Output mux on current queue
   assign cur_word = head_word[cur_queue];
   assign {m_axis_tlast, m_axis_tuser, m_axis_tstrb, m_axis_tdata} = cur_word;
   assign m_axis_tvalid = ~empty[cur_queue];

   assign xfer     = m_axis_tvalid & m_axis_tready;
   assign pkt_done = xfer & m_axis_tlast;  // One pulse per packet end

   // Wrap from last queue back to 0
   assign cur_queue_plus1 = (cur_queue == QUEUE_W'(NUM_QUEUES - 1)) ? '0
                                                                     : cur_queue + 1'b1;

   always_comb begin
      state_next     = state;
      cur_queue_next = cur_queue;
      rd_en          = '0;

      case (state)
         ARB_IDLE: begin
            if (!m_axis_tvalid) begin
               cur_queue_next = cur_queue_plus1;  // Nothing here, try next queue
            end else if (m_axis_tready) begin
               rd_en[cur_queue] = 1'b1;
               if (m_axis_tlast) begin
                  // Single-word packet, done already
                  cur_queue_next = cur_queue_plus1;
               end else begin
                  state_next = ARB_WR_PKT;
               end
            end
         end

         ARB_WR_PKT: begin
            // Only pop when the head is valid and the sink takes it
            if (xfer) begin
               rd_en[cur_queue] = 1'b1;
               if (m_axis_tlast) begin
                  state_next     = ARB_IDLE;
                  cur_queue_next = cur_queue_plus1;  // Give the next queue a turn
               end
            end
         end

         default: begin
            state_next = ARB_IDLE;
         end
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state     <= ARB_IDLE;
         cur_queue <= '0;  // Start at queue 0
      end else begin
         state     <= state_next;
         cur_queue <= cur_queue_next;
      end
   end

endmodule

//--- hdl/osnt_input_arbiter.sv
`timescale 1ns/1ps

module osnt_input_arbiter
   import arb_pkg::*;
(
   input  logic                 axi_aclk,
   input  logic                 axi_resetn,

   // Merged output stream
   output logic [DATA_W-1:0]    m_axis_tdata,
   output logic [STRB_W-1:0]    m_axis_tstrb,
   output logic [USER_W-1:0]    m_axis_tuser,
   output logic                 m_axis_tvalid,
   input  logic                 m_axis_tready,
   output logic                 m_axis_tlast,

   // Receive streams
   input  logic [DATA_W-1:0]    s_axis_tdata_0,
   input  logic [STRB_W-1:0]    s_axis_tstrb_0,
   input  logic [USER_W-1:0]    s_axis_tuser_0,
   input  logic                 s_axis_tvalid_0,
   output logic                 s_axis_tready_0,
   input  logic                 s_axis_tlast_0,

   input  logic [DATA_W-1:0]    s_axis_tdata_1,
   input  logic [STRB_W-1:0]    s_axis_tstrb_1,
   input  logic [USER_W-1:0]    s_axis_tuser_1,
   input  logic                 s_axis_tvalid_1,
   output logic                 s_axis_tready_1,
   input  logic                 s_axis_tlast_1,

   input  logic [DATA_W-1:0]    s_axis_tdata_2,
   input  logic [STRB_W-1:0]    s_axis_tstrb_2,
   input  logic [USER_W-1:0]    s_axis_tuser_2,
   input  logic                 s_axis_tvalid_2,
   output logic                 s_axis_tready_2,
   input  logic                 s_axis_tlast_2,

   input  logic [DATA_W-1:0]    s_axis_tdata_3,
   input  logic [STRB_W-1:0]    s_axis_tstrb_3,
   input  logic [USER_W-1:0]    s_axis_tuser_3,
   input  logic                 s_axis_tvalid_3,
   output logic                 s_axis_tready_3,
   input  logic                 s_axis_tlast_3,

   // Statistics read-out
   input  logic [QUEUE_W-1:0]   stat_sel,
   output logic [PKT_CNT_W-1:0] stat_pkt_count
);

   logic [FIFO_W-1:0]     fifo_din  [NUM_QUEUES];  // Packed input words
   logic [FIFO_W-1:0]     fifo_dout [NUM_QUEUES];  // FIFO heads
   logic [NUM_QUEUES-1:0] in_tvalid;
   logic [NUM_QUEUES-1:0] nearly_full;
   logic [NUM_QUEUES-1:0] empty;
   logic [NUM_QUEUES-1:0] rd_en;
   logic [QUEUE_W-1:0]    cur_queue;
   logic                  pkt_done;

   // Same field order as the FSM unpacks
   assign fifo_din[0] = {s_axis_tlast_0, s_axis_tuser_0, s_axis_tstrb_0, s_axis_tdata_0};
   assign fifo_din[1] = {s_axis_tlast_1, s_axis_tuser_1, s_axis_tstrb_1, s_axis_tdata_1};
   assign fifo_din[2] = {s_axis_tlast_2, s_axis_tuser_2, s_axis_tstrb_2, s_axis_tdata_2};
   assign fifo_din[3] = {s_axis_tlast_3, s_axis_tuser_3, s_axis_tstrb_3, s_axis_tdata_3};

   assign in_tvalid = {s_axis_tvalid_3, s_axis_tvalid_2, s_axis_tvalid_1, s_axis_tvalid_0};

   // Accept while the FIFO has room
   assign s_axis_tready_0 = ~nearly_full[0];
   assign s_axis_tready_1 = ~nearly_full[1];
   assign s_axis_tready_2 = ~nearly_full[2];
   assign s_axis_tready_3 = ~nearly_full[3];

   for (genvar i = 0; i < NUM_QUEUES; i++) begin : g_in_fifo
      fallthrough_small_fifo in_arb_fifo (
         .axi_aclk    (axi_aclk),
         .axi_resetn  (axi_resetn),
         .din         (fifo_din[i]),
         .wr_en       (in_tvalid[i] & ~nearly_full[i]),  // Write on tvalid and tready
         .rd_en       (rd_en[i]),
         .dout        (fifo_dout[i]),
         .empty       (empty[i]),
         .nearly_full (nearly_full[i])
      );
   end

   input_arbiter_fsm arb_fsm (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .empty         (empty),
      .head_word     (fifo_dout),
      .m_axis_tready (m_axis_tready),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tstrb  (m_axis_tstrb),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tlast  (m_axis_tlast),
      .m_axis_tvalid (m_axis_tvalid),
      .rd_en         (rd_en),
      .cur_queue     (cur_queue),
      .pkt_done      (pkt_done)
   );

   pkt_counter stats (
      .axi_aclk       (axi_aclk),
      .axi_resetn     (axi_resetn),
      .pkt_done       (pkt_done),
      .cur_queue      (cur_queue),
      .stat_sel       (stat_sel),
      .stat_pkt_count (stat_pkt_count)
   );

endmodule

//--- hdl/pkt_counter.sv
`timescale 1ns/1ps

module pkt_counter
   import arb_pkg::*;
(
   input  logic                 axi_aclk,
   input  logic                 axi_resetn,
   input  logic                 pkt_done,
   input  logic [QUEUE_W-1:0]   cur_queue,
   input  logic [QUEUE_W-1:0]   stat_sel,
   output logic [PKT_CNT_W-1:0] stat_pkt_count
);

   // One forwarded-packet count per input queue
   logic [PKT_CNT_W-1:0] pkt_cnt [NUM_QUEUES];

   // Bump the active queue on each tlast beat
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         for (int unsigned q = 0; q < NUM_QUEUES; q++) begin
            pkt_cnt[q] <= '0;
         end
      end else if (pkt_done) begin
         pkt_cnt[cur_queue] <= pkt_cnt[cur_queue] + 1'b1;  // Rolls over at full scale
      end
   end

   // Registered read-out, one cycle behind stat_sel
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         stat_pkt_count <= '0;
      end else begin
         stat_pkt_count <= pkt_cnt[stat_sel];
      end
   end

endmodule

//--- tests/input_arbiter_assertions.sv
`timescale 1ns/1ps

module input_arbiter_assertions
   import arb_pkg::*;
(
   input logic                  axi_aclk,
   input logic                  axi_resetn,
   input logic [DATA_W-1:0]     m_axis_tdata,
   input logic [STRB_W-1:0]     m_axis_tstrb,
   input logic [USER_W-1:0]     m_axis_tuser,
   input logic                  m_axis_tlast,
   input logic                  m_axis_tvalid,
   input logic                  m_axis_tready,
   input logic [NUM_QUEUES-1:0] s_axis_tready,
   input logic [QUEUE_W-1:0]    cur_queue
);

   bit assert_failed = 1'b0;  // Sticky failure flag

   // Idle outputs while in reset and one cycle after
   a_reset_state: assert property (@(posedge axi_aclk)
      !axi_resetn |=> (!m_axis_tvalid && (&s_axis_tready)))
      else begin
         $error("Output valid high or an input ready low around reset");
         assert_failed = 1'b1;
      end

   // Stalled word must hold
   a_stall_hold: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid &&
         $stable({m_axis_tdata, m_axis_tstrb, m_axis_tuser, m_axis_tlast})))
      else begin
         $error("Output word or valid changed while the sink stalled");
         assert_failed = 1'b1;
      end

   a_stall_queue: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      (m_axis_tvalid && !m_axis_tready) |=> $stable(cur_queue))
      else begin
         $error("Queue pointer moved while the sink stalled");
         assert_failed = 1'b1;
      end

endmodule

bind osnt_input_arbiter input_arbiter_assertions assertions_inst (
   .axi_aclk      (axi_aclk),
   .axi_resetn    (axi_resetn),
   .m_axis_tdata  (m_axis_tdata),
   .m_axis_tstrb  (m_axis_tstrb),
   .m_axis_tuser  (m_axis_tuser),
   .m_axis_tlast  (m_axis_tlast),
   .m_axis_tvalid (m_axis_tvalid),
   .m_axis_tready (m_axis_tready),
   .s_axis_tready ({s_axis_tready_3, s_axis_tready_2, s_axis_tready_1, s_axis_tready_0}),
   .cur_queue     (cur_queue)
);

//--- tests/tb_input_arbiter.sv
`timescale 1ns/1ps

module tb_input_arbiter
   import arb_pkg::*;
();

   localparam int          PKTS_PER_SRC = 40;      // Packets sent by each source
   localparam int          WAIT_LIMIT   = 20000;   // Cycles per wait loop
   localparam logic [15:0] LFSR_SEED    = 16'd35854;
   localparam logic [15:0] LFSR_TAPS    = 16'hB400;  // x^16 + x^14 + x^13 + x^11 + 1

   logic                  axi_aclk;
   logic                  axi_resetn;
   logic [DATA_W-1:0]     in_tdata [NUM_QUEUES];
   logic [STRB_W-1:0]     in_tstrb [NUM_QUEUES];
   logic [USER_W-1:0]     in_tuser [NUM_QUEUES];
   logic [NUM_QUEUES-1:0] in_tvalid;
   logic [NUM_QUEUES-1:0] in_tlast;
   wire  [NUM_QUEUES-1:0] in_tready;
   logic [DATA_W-1:0]     m_axis_tdata;
   logic [STRB_W-1:0]     m_axis_tstrb;
   logic [USER_W-1:0]     m_axis_tuser;
   logic                  m_axis_tvalid;
   logic                  m_axis_tlast;
   logic                  m_axis_tready;
   logic [QUEUE_W-1:0]    stat_sel;
   logic [PKT_CNT_W-1:0]  stat_pkt_count;

   logic [15:0]           lfsr_state;
   int                    words_left [NUM_QUEUES];  // Words still to offer in current packet
   int                    pkts_sent [NUM_QUEUES];
   int                    sink_mode;                // 0 ready, 1 stalled, 2 random
   int                    phase_left;
   logic                  stim_en;
   logic                  drain;                    // Sink forced ready at the end

   logic [FIFO_W-1:0]     ref_q [NUM_QUEUES][$];    // Expected words per source
   int                    tlast_cnt [NUM_QUEUES];
   logic                  in_pkt;
   logic [QUEUE_W-1:0]    pkt_src;
   logic                  rr_armed;                 // Next queue had data at last tlast
   logic [QUEUE_W-1:0]    rr_expect;
   int                    rr_checks;

   always #5 axi_aclk = ~axi_aclk;

   osnt_input_arbiter osnt_input_arbiter_inst (
      .axi_aclk        (axi_aclk),
      .axi_resetn      (axi_resetn),
      .m_axis_tdata    (m_axis_tdata),
      .m_axis_tstrb    (m_axis_tstrb),
      .m_axis_tuser    (m_axis_tuser),
      .m_axis_tvalid   (m_axis_tvalid),
      .m_axis_tready   (m_axis_tready),
      .m_axis_tlast    (m_axis_tlast),
      .s_axis_tdata_0  (in_tdata[0]),
      .s_axis_tstrb_0  (in_tstrb[0]),
      .s_axis_tuser_0  (in_tuser[0]),
      .s_axis_tvalid_0 (in_tvalid[0]),
      .s_axis_tready_0 (in_tready[0]),
      .s_axis_tlast_0  (in_tlast[0]),
      .s_axis_tdata_1  (in_tdata[1]),
      .s_axis_tstrb_1  (in_tstrb[1]),
      .s_axis_tuser_1  (in_tuser[1]),
      .s_axis_tvalid_1 (in_tvalid[1]),
      .s_axis_tready_1 (in_tready[1]),
      .s_axis_tlast_1  (in_tlast[1]),
      .s_axis_tdata_2  (in_tdata[2]),
      .s_axis_tstrb_2  (in_tstrb[2]),
      .s_axis_tuser_2  (in_tuser[2]),
      .s_axis_tvalid_2 (in_tvalid[2]),
      .s_axis_tready_2 (in_tready[2]),
      .s_axis_tlast_2  (in_tlast[2]),
      .s_axis_tdata_3  (in_tdata[3]),
      .s_axis_tstrb_3  (in_tstrb[3]),
      .s_axis_tuser_3  (in_tuser[3]),
      .s_axis_tvalid_3 (in_tvalid[3]),
      .s_axis_tready_3 (in_tready[3]),
      .s_axis_tlast_3  (in_tlast[3]),
      .stat_sel        (stat_sel),
      .stat_pkt_count  (stat_pkt_count)
   );

   // Galois LFSR stepped once per bit returned
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      logic        lsb;
      v = '0;
      for (int k = 0; k < n; k++) begin
         lsb        = lfsr_state[0];
         lfsr_state = lfsr_state >> 1;
         if (lsb) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
         end
         v = {v[62:0], lsb};
      end
      return v;
   endfunction

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1, "Stopping at first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (expected === actual)
         else fail_stop($sformatf("[FAIL] %s expected 0x%0h actual 0x%0h",
                                  name, expected, actual));
   endtask

   function automatic logic sources_done();
      logic done;
      done = (in_tvalid == '0);  // Last word of each source taken
      for (int i = 0; i < NUM_QUEUES; i++) begin
         done &= (pkts_sent[i] == PKTS_PER_SRC);
      end
      return done;
   endfunction

   function automatic logic queues_empty();
      logic none_left;
      none_left = 1'b1;
      for (int i = 0; i < NUM_QUEUES; i++) begin
         none_left &= (ref_q[i].size() == 0);
      end
      return none_left;
   endfunction

   // Sources and sink drive DUT inputs on the rising edge
   always @(posedge axi_aclk) begin
      if (stim_en) begin
         for (int i = 0; i < NUM_QUEUES; i++) begin
            if (!in_tvalid[i] || in_tready[i]) begin  // Slot free so offer next word or idle
               if (pkts_sent[i] < PKTS_PER_SRC && rand_bits(2) != 0) begin
                  if (words_left[i] == 0) begin
                     words_left[i] = 1 + int'(rand_bits(8) % 6);  // 1 to 6 words
                  end
                  in_tdata[i]  <= rand_bits(DATA_W);
                  in_tstrb[i]  <= STRB_W'(rand_bits(STRB_W));
                  in_tuser[i]  <= {(USER_W-QUEUE_W)'(pkts_sent[i]), QUEUE_W'(i)};
                  in_tlast[i]  <= (words_left[i] == 1);
                  in_tvalid[i] <= 1'b1;
                  words_left[i]--;
                  if (words_left[i] == 0) begin
                     pkts_sent[i]++;
                  end
               end else begin
                  in_tvalid[i] <= 1'b0;  // Gap
               end
            end
         end
         if (drain) begin
            m_axis_tready <= 1'b1;
         end else begin
            if (phase_left == 0) begin
               sink_mode  = int'(rand_bits(2) % 3);
               phase_left = 8 + int'(rand_bits(5));
            end
            phase_left--;
            case (sink_mode)
               0:       m_axis_tready <= 1'b1;
               1:       m_axis_tready <= 1'b0;  // Long stall lets FIFOs fill
               default: m_axis_tready <= (rand_bits(1) != 0);
            endcase
         end
      end
   end

   // Scoreboard pushes accepted inputs before it pops
   always @(posedge axi_aclk) begin
      logic [FIFO_W-1:0]  exp_word;
      logic [QUEUE_W-1:0] src;
      if (axi_resetn) begin
         for (int i = 0; i < NUM_QUEUES; i++) begin
            if (in_tvalid[i] && in_tready[i]) begin
               ref_q[i].push_back({in_tlast[i], in_tuser[i], in_tstrb[i], in_tdata[i]});
            end
         end
         if (m_axis_tvalid && m_axis_tready) begin
            src = m_axis_tuser[QUEUE_W-1:0];
            assert (ref_q[src].size() > 0)
               else fail_stop($sformatf("Output word names source %0d with nothing queued", src));
            exp_word = ref_q[src].pop_front();
            check_value("m_axis_tdata", exp_word[DATA_W-1:0], m_axis_tdata);
            check_value("m_axis_tstrb", exp_word[DATA_W +: STRB_W], m_axis_tstrb);
            check_value("m_axis_tuser", exp_word[DATA_W+STRB_W +: USER_W], m_axis_tuser);
            check_value("m_axis_tlast", exp_word[FIFO_W-1], m_axis_tlast);
            if (in_pkt) begin
               check_value("m_axis_tuser source", pkt_src, src);  // Source fixed within a packet
            end else if (rr_armed) begin
               check_value("m_axis_tuser round-robin source", rr_expect, src);
               rr_checks++;
            end
            if (m_axis_tlast) begin
               tlast_cnt[src]++;
               in_pkt    = 1'b0;
               rr_expect = src + 1'b1;  // Wraps 3 to 0
               rr_armed  = (ref_q[rr_expect].size() != 0);
            end else begin
               in_pkt  = 1'b1;
               pkt_src = src;
            end
         end
      end
   end

   // Bound protocol checks raise this flag
   always @(posedge axi_aclk) begin
      if (osnt_input_arbiter_inst.assertions_inst.assert_failed) begin
         fail_stop("A protocol assertion on the DUT failed");
      end
   end

   initial begin
      int cyc;
      axi_aclk      = 1'b0;
      axi_resetn    = 1'b0;
      lfsr_state    = LFSR_SEED;
      stim_en       = 1'b0;
      drain         = 1'b0;
      m_axis_tready = 1'b0;
      stat_sel      = '0;
      in_tvalid     = '0;
      in_tlast      = '0;
      for (int i = 0; i < NUM_QUEUES; i++) begin
         in_tdata[i]   = '0;
         in_tstrb[i]   = '0;
         in_tuser[i]   = '0;
         words_left[i] = 0;
         pkts_sent[i]  = 0;
         tlast_cnt[i]  = 0;
      end
      sink_mode  = 0;
      phase_left = 0;
      in_pkt     = 1'b0;
      pkt_src    = '0;
      rr_armed   = 1'b0;
      rr_expect  = '0;
      rr_checks  = 0;

      repeat (4) @(posedge axi_aclk);
      axi_resetn <= 1'b1;
      stim_en    <= 1'b1;

      cyc = 0;
      while (!sources_done() && cyc < WAIT_LIMIT) begin
         @(negedge axi_aclk);
         cyc++;
      end
      if (!sources_done()) begin
         fail_stop("Timed out waiting for the sources to send all packets");
      end

      drain = 1'b1;
      cyc   = 0;
      while (!queues_empty() && cyc < WAIT_LIMIT) begin
         @(negedge axi_aclk);
         cyc++;
      end
      if (!queues_empty()) begin
         fail_stop("Timed out waiting for the output to drain");
      end

      // Counter read-out is one cycle behind stat_sel
      for (int q = 0; q < NUM_QUEUES; q++) begin
         @(posedge axi_aclk);
         stat_sel <= QUEUE_W'(q);
         @(posedge axi_aclk);
         @(negedge axi_aclk);
         check_value($sformatf("stat_pkt_count[%0d]", q), PKT_CNT_W'(tlast_cnt[q]),
                     stat_pkt_count);
      end

      if (rr_checks == 0) begin
         fail_stop("Round-robin order was never exercised with a waiting queue");
      end else if (osnt_input_arbiter_inst.assertions_inst.assert_failed) begin
         fail_stop("A protocol assertion on the DUT failed");
      end else begin
         $display("Everything OK");
         $finish;
      end
   end

endmodule

//--- vlog.f
hdl/arb_pkg.sv
hdl/fallthrough_small_fifo.sv
hdl/input_arbiter_fsm.sv
hdl/pkt_counter.sv
hdl/osnt_input_arbiter.sv
tests/input_arbiter_assertions.sv
tests/tb_input_arbiter.sv
